// ==== rtl/cpu_pkg.sv ====
// fixed 16-bit isa; no stack pointer or special operands, opcodes 14, 15 and 24..31 act as no-ops
package cpu_pkg;

    localparam int word_width = 16;
    localparam int reg_addr_width = 3;
    localparam int cc_width = 4;

    // major opcodes in bits 15..11, alu ops occupy 0..11
    localparam logic [4:0] op_alu_max = 5'd11;
    localparam logic [4:0] op_load = 5'd12;
    localparam logic [4:0] op_store = 5'd13;
    // branch group 16..23, top two bits
    localparam logic [1:0] op_branch_group = 2'b10;

    // alu operations, low four opcode bits
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_adc = 4'd1;
    localparam logic [3:0] alu_sub = 4'd2;
    localparam logic [3:0] alu_sbc = 4'd3;
    localparam logic [3:0] alu_and = 4'd4;
    localparam logic [3:0] alu_or = 4'd5;
    localparam logic [3:0] alu_xor = 4'd6;
    localparam logic [3:0] alu_mov = 4'd7;
    localparam logic [3:0] alu_lsl = 4'd8;
    localparam logic [3:0] alu_lsr = 4'd9;
    localparam logic [3:0] alu_asr = 4'd10;
    localparam logic [3:0] alu_mvn = 4'd11;

    // branch conditions
    localparam logic [3:0] cond_eq = 4'd0;
    localparam logic [3:0] cond_ne = 4'd1;
    localparam logic [3:0] cond_cs = 4'd2;
    localparam logic [3:0] cond_cc = 4'd3;
    localparam logic [3:0] cond_mi = 4'd4;
    localparam logic [3:0] cond_pl = 4'd5;
    localparam logic [3:0] cond_vs = 4'd6;
    localparam logic [3:0] cond_vc = 4'd7;
    localparam logic [3:0] cond_hi = 4'd8;
    localparam logic [3:0] cond_ls = 4'd9;
    localparam logic [3:0] cond_ge = 4'd10;
    localparam logic [3:0] cond_lt = 4'd11;
    localparam logic [3:0] cond_gt = 4'd12;
    localparam logic [3:0] cond_le = 4'd13;
    localparam logic [3:0] cond_al = 4'd14;
    // nv marks the long and register branch forms
    localparam logic [3:0] cond_nv = 4'd15;

    // second operand modes, imm4 sign is the low mode bit
    localparam logic [1:0] mode_imm_pos = 2'b00;
    localparam logic [1:0] mode_imm_neg = 2'b01;
    localparam logic [1:0] mode_reg = 2'b10;
    localparam logic [1:0] mode_ext = 2'b11;

    // bits 3..0 are shared by both views:
    // register-branch target in op.b, special (lr) bit in op.mode[0]
    // bit 9 doubles as the link bit of long and register branches
    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [reg_addr_width-1:0] d;
            logic [reg_addr_width-1:0] a;
            logic [1:0] mode;
            logic [reg_addr_width-1:0] b;
        } op;
        struct packed {
            logic [1:0] group;
            logic [3:0] cond;
            logic signed [9:0] offset;
        } br;
    } instr_u;

endpackage

// ==== rtl/core_ifs.sv ====
// plain signal bundles with no clocking; every signal is combinational across the boundary
`timescale 1ns/10ps

// exec unit steers fetch and borrows the shared bus for loads and stores
interface fetch_if;
    logic take_branch;
    logic [cpu_pkg::word_width-1:0] target;
    logic stall;
    logic ls_active;
    logic ls_write;
    logic [cpu_pkg::word_width-1:0] ls_addr;
    // raw bus read data, instruction or load data
    logic [cpu_pkg::word_width-1:0] instr;
    logic instr_valid;
    logic [cpu_pkg::word_width-1:0] pc;

    modport fetch_side (
        input  take_branch, target, stall, ls_active, ls_write, ls_addr,
        output instr, instr_valid, pc
    );

    modport exec_side (
        output take_branch, target, stall, ls_active, ls_write, ls_addr,
        input  instr, instr_valid, pc
    );
endinterface

// three read ports a, b, d and one write port
interface regfile_if;
    logic [cpu_pkg::reg_addr_width-1:0] raddr_a;
    logic [cpu_pkg::reg_addr_width-1:0] raddr_b;
    logic [cpu_pkg::reg_addr_width-1:0] raddr_d;
    logic [cpu_pkg::word_width-1:0] rdata_a;
    logic [cpu_pkg::word_width-1:0] rdata_b;
    logic [cpu_pkg::word_width-1:0] rdata_d;
    logic we;
    logic [cpu_pkg::reg_addr_width-1:0] waddr;
    logic [cpu_pkg::word_width-1:0] wdata;

    modport exec_side (
        output raddr_a, raddr_b, raddr_d, we, waddr, wdata,
        input  rdata_a, rdata_b, rdata_d
    );

    modport file_side (
        input  raddr_a, raddr_b, raddr_d, we, waddr, wdata,
        output rdata_a, rdata_b, rdata_d
    );
endinterface

// ==== rtl/alu.sv ====
// purely combinational; op codes 12..15 are never issued and fall back to add
`timescale 1ns/10ps

module alu (
    input  logic [3:0] op,
    input  logic [cpu_pkg::word_width-1:0] a,
    input  logic [cpu_pkg::word_width-1:0] b,
    input  logic [cpu_pkg::cc_width-1:0] cc_in,
    output logic [cpu_pkg::word_width-1:0] result,
    output logic [cpu_pkg::cc_width-1:0] cc_out
);

    localparam int w = cpu_pkg::word_width;

    logic [w-1:0] b_eff;
    logic carry_in;
    logic [w:0] sum;
    logic arith;

    always_comb begin
        // subtract adds ~b, so carry out is not-borrow
        b_eff = (op == cpu_pkg::alu_sub || op == cpu_pkg::alu_sbc) ? ~b : b;
        case (op)
            cpu_pkg::alu_add: carry_in = 1'b0;
            cpu_pkg::alu_sub: carry_in = 1'b1;
            // adc and sbc chain the old carry
            default: carry_in = cc_in[1];
        endcase
        sum = {1'b0, a} + {1'b0, b_eff} + {{w{1'b0}}, carry_in};
        arith = op inside {cpu_pkg::alu_add, cpu_pkg::alu_adc, cpu_pkg::alu_sub, cpu_pkg::alu_sbc};

        // shift amounts use b mod 16
        case (op)
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or: result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_mov: result = b;
            cpu_pkg::alu_lsl: result = a << b[3:0];
            cpu_pkg::alu_lsr: result = a >> b[3:0];
            cpu_pkg::alu_asr: result = $signed(a) >>> b[3:0];
            cpu_pkg::alu_mvn: result = ~b;
            default: result = sum[w-1:0];
        endcase

        // n z c v
        cc_out[3] = result[w-1];
        cc_out[2] = result == '0;
        cc_out[1] = arith ? sum[w] : cc_in[1];
        // overflow when both addends share a sign the result lacks
        cc_out[0] = arith ? (a[w-1] == b_eff[w-1]) && (result[w-1] != a[w-1]) : cc_in[0];
    end

endmodule

// ==== rtl/regfile.sv ====
// r0 always reads zero and drops writes; reads are combinational, write lands at the edge
`timescale 1ns/10ps

module regfile (
    input  logic clk,
    input  logic rst,
    regfile_if.file_side regs
);

    localparam int depth = 2 ** cpu_pkg::reg_addr_width;

    logic [cpu_pkg::word_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (regs.we && regs.waddr != '0) begin
            mem[regs.waddr] <= regs.wdata;
        end
    end

    // no write-through, a reader sees the value before this cycle's write
    assign regs.rdata_a = (regs.raddr_a == '0) ? '0 : mem[regs.raddr_a];
    assign regs.rdata_b = (regs.raddr_b == '0) ? '0 : mem[regs.raddr_b];
    assign regs.rdata_d = (regs.raddr_d == '0) ? '0 : mem[regs.raddr_d];

endmodule

// ==== rtl/fetch_unit.sv ====
// assumes a bus with one-cycle synchronous reads; first fetch lands at reset_vector + 1
`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [cpu_pkg::word_width-1:0] reset_vector = 16'hffff
) (
    input  logic clk,
    input  logic rst,
    fetch_if.fetch_side fetch,
    output logic [cpu_pkg::word_width-1:0] addr,
    input  logic [cpu_pkg::word_width-1:0] rdata,
    output logic re,
    output logic we
);

    logic [cpu_pkg::word_width-1:0] pc;
    logic [cpu_pkg::word_width-1:0] pc_next;
    logic fetch_cycle;

    // next fetch address, same cycle as the exec request
    always_comb begin
        if (fetch.stall) begin
            pc_next = pc;
        end else if (fetch.take_branch) begin
            pc_next = fetch.target;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    // load or store owns the bus over the fetch
    assign fetch_cycle = !rst && !fetch.ls_active;
    assign addr = fetch.ls_active ? fetch.ls_addr : pc_next;
    // bus is quiet in reset
    assign re = !rst && !(fetch.ls_active && fetch.ls_write);
    assign we = !rst && fetch.ls_active && fetch.ls_write;

    // read data is whatever came back this cycle
    assign fetch.instr = rdata;
    assign fetch.pc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
            fetch.instr_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            // rdata next cycle holds an instruction only after a fetch cycle
            fetch.instr_valid <= fetch_cycle;
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
// one instruction in decode at a time; no interrupts, traps or special-register operands
`timescale 1ns/10ps

module exec_unit (
    input  logic clk,
    input  logic rst,
    fetch_if.exec_side fetch,
    regfile_if.exec_side regs,
    output logic [3:0] alu_op,
    output logic [cpu_pkg::word_width-1:0] alu_a,
    output logic [cpu_pkg::word_width-1:0] alu_b,
    output logic [cpu_pkg::cc_width-1:0] alu_cc_in,
    input  logic [cpu_pkg::word_width-1:0] alu_result,
    input  logic [cpu_pkg::cc_width-1:0] alu_cc,
    output logic [cpu_pkg::word_width-1:0] wdata
);

    localparam int w = cpu_pkg::word_width;

    localparam logic [2:0] st_decode = 3'd0;
    localparam logic [2:0] st_immediate = 3'd1;
    localparam logic [2:0] st_ls1 = 3'd2;
    localparam logic [2:0] st_ls2 = 3'd3;
    localparam logic [2:0] st_branch_delay = 3'd4;

    cpu_pkg::instr_u ir;
    logic ir_valid;
    logic [2:0] state;
    logic [2:0] state_next;
    logic [w-1:0] imm;
    logic [w-1:0] lr;
    logic [w-1:0] lr_next;
    logic [cpu_pkg::cc_width-1:0] cc;
    logic [cpu_pkg::cc_width-1:0] cc_next;

    logic is_alu, is_load, is_store, is_branch;
    logic is_short, is_regbr, is_long;
    logic reg_special, link, imm_fetch, cond_true;
    logic flag_n, flag_z, flag_c, flag_v;

    // decode through the two views
    assign is_alu = ir.op.opcode <= cpu_pkg::op_alu_max;
    assign is_load = ir.op.opcode == cpu_pkg::op_load;
    assign is_store = ir.op.opcode == cpu_pkg::op_store;
    assign is_branch = ir.br.group == cpu_pkg::op_branch_group;
    assign is_short = is_branch && ir.br.cond != cpu_pkg::cond_nv;
    assign reg_special = ir.op.mode[0];
    assign link = ir.br.offset[9];
    // nv form: special bit or nonzero rb is a register branch, else long
    assign is_regbr = is_branch && !is_short && (reg_special || ir.op.b != '0);
    assign is_long = is_branch && !is_short && !is_regbr;

    // second word is still on rdata in the first decode cycle
    assign imm_fetch = ir_valid && state == st_decode
        && (is_long || ((is_alu || is_load || is_store) && ir.op.mode == cpu_pkg::mode_ext));

    assign {flag_n, flag_z, flag_c, flag_v} = cc;

    always_comb begin
        case (ir.br.cond)
            cpu_pkg::cond_eq: cond_true = flag_z;
            cpu_pkg::cond_ne: cond_true = !flag_z;
            cpu_pkg::cond_cs: cond_true = flag_c;
            cpu_pkg::cond_cc: cond_true = !flag_c;
            cpu_pkg::cond_mi: cond_true = flag_n;
            cpu_pkg::cond_pl: cond_true = !flag_n;
            cpu_pkg::cond_vs: cond_true = flag_v;
            cpu_pkg::cond_vc: cond_true = !flag_v;
            // unsigned higher / lower-or-same
            cpu_pkg::cond_hi: cond_true = flag_c && !flag_z;
            cpu_pkg::cond_ls: cond_true = !flag_c || flag_z;
            cpu_pkg::cond_ge: cond_true = flag_n == flag_v;
            cpu_pkg::cond_lt: cond_true = flag_n != flag_v;
            cpu_pkg::cond_gt: cond_true = !flag_z && (flag_n == flag_v);
            cpu_pkg::cond_le: cond_true = flag_z || (flag_n != flag_v);
            cpu_pkg::cond_al: cond_true = 1'b1;
            cpu_pkg::cond_nv: cond_true = 1'b0;
        endcase
    end

    // second operand
    always_comb begin
        case (ir.op.mode)
            cpu_pkg::mode_imm_pos,
            cpu_pkg::mode_imm_neg: alu_b = {{(w - 4){reg_special}}, reg_special, ir.op.b};
            cpu_pkg::mode_reg: alu_b = regs.rdata_b;
            cpu_pkg::mode_ext: alu_b = imm;
        endcase
    end

    // fetch.pc is already A+L at the step that uses it
    assign fetch.target = is_short ? fetch.pc + {{(w - 10){ir.br.offset[9]}}, ir.br.offset}
        : is_regbr ? (reg_special ? lr : regs.rdata_b)
        : fetch.pc + imm;

    // loads and stores compute the address as a + operand
    assign alu_op = is_alu ? ir.op.opcode[3:0] : cpu_pkg::alu_add;
    assign alu_a = regs.rdata_a;
    assign alu_cc_in = cc;
    assign fetch.ls_addr = alu_result;
    assign fetch.ls_write = is_store;
    assign wdata = regs.rdata_d;

    assign regs.raddr_a = ir.op.a;
    assign regs.raddr_b = ir.op.b;
    assign regs.raddr_d = ir.op.d;
    assign regs.waddr = ir.op.d;

    always_comb begin
        state_next = state;
        cc_next = cc;
        lr_next = lr;
        fetch.take_branch = 1'b0;
        fetch.stall = 1'b0;
        fetch.ls_active = 1'b0;
        regs.we = 1'b0;
        regs.wdata = alu_result;
        case (state)
            st_ls1: begin
                // load data on rdata now, refetch the held pc
                state_next = st_ls2;
                fetch.stall = 1'b1;
                if (is_load) begin
                    regs.we = 1'b1;
                    regs.wdata = fetch.instr;
                end
            end
            // drop the word fetched before the redirect or refetch
            st_ls2,
            st_branch_delay: begin
                state_next = st_decode;
            end
            default: begin
                if (imm_fetch) begin
                    state_next = st_immediate;
                end else if (ir_valid) begin
                    // final decode step
                    state_next = st_decode;
                    if (is_alu) begin
                        regs.we = 1'b1;
                        cc_next = alu_cc;
                    end else if (is_load || is_store) begin
                        fetch.ls_active = 1'b1;
                        fetch.stall = 1'b1;
                        state_next = st_ls1;
                    end else if (is_short) begin
                        fetch.take_branch = cond_true;
                        if (cond_true) begin
                            state_next = st_branch_delay;
                        end
                    end else if (is_branch) begin
                        fetch.take_branch = 1'b1;
                        state_next = st_branch_delay;
                        if (link) begin
                            lr_next = fetch.pc;
                        end
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_decode;
            ir_valid <= 1'b0;
            cc <= '0;
            lr <= '0;
        end else begin
            state <= state_next;
            cc <= cc_next;
            lr <= lr_next;
            // a bubble enters as an invalid instruction
            if (state_next == st_decode) begin
                ir_valid <= fetch.instr_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_next == st_decode) begin
            ir <= fetch.instr;
        end
        if (imm_fetch) begin
            imm <= fetch.instr;
        end
    end

endmodule

// ==== rtl/cpu_top.sv ====
// single shared bus, one-cycle synchronous reads, no wait states or back-pressure
`timescale 1ns/10ps

module cpu_top #(
    parameter logic [cpu_pkg::word_width-1:0] reset_vector = 16'hffff
) (
    input  logic clk,
    input  logic rst,
    output logic [cpu_pkg::word_width-1:0] addr,
    input  logic [cpu_pkg::word_width-1:0] rdata,
    output logic [cpu_pkg::word_width-1:0] wdata,
    output logic re,
    output logic we
);

    fetch_if fetch ();
    regfile_if regs ();

    logic [3:0] alu_op;
    logic [cpu_pkg::word_width-1:0] alu_a;
    logic [cpu_pkg::word_width-1:0] alu_b;
    logic [cpu_pkg::word_width-1:0] alu_result;
    logic [cpu_pkg::cc_width-1:0] alu_cc_in;
    logic [cpu_pkg::cc_width-1:0] alu_cc;

    // stage 1, pc and bus arbitration
    fetch_unit #(
        .reset_vector(reset_vector)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .addr(addr),
        .rdata(rdata),
        .re(re),
        .we(we)
    );

    // stage 2, decode and execute
    exec_unit u_exec (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .regs(regs),
        .alu_op(alu_op),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .alu_cc_in(alu_cc_in),
        .alu_result(alu_result),
        .alu_cc(alu_cc),
        .wdata(wdata)
    );

    alu u_alu (
        .op(alu_op),
        .a(alu_a),
        .b(alu_b),
        .cc_in(alu_cc_in),
        .result(alu_result),
        .cc_out(alu_cc)
    );

    regfile u_regfile (
        .clk(clk),
        .rst(rst),
        .regs(regs)
    );

endmodule

// ==== testbench/cpu_asserts.sv ====
// bus protocol checks only, bound onto cpu_top
`timescale 1ns/10ps

module cpu_asserts (
    input logic clk,
    input logic rst,
    input logic re,
    input logic we,
    input logic [15:0] addr
);

    // bus quiet during reset
    quiet_in_reset: assert property (@(posedge clk) rst |-> !re && !we)
        else $error("bus active during reset");

    // one direction per cycle
    one_direction: assert property (@(posedge clk) !(re && we))
        else $error("read and write in the same cycle");

    known_addr: assert property (@(posedge clk) (re || we) |-> !$isunknown(addr))
        else $error("unknown address on an active bus cycle");

endmodule

bind cpu_top cpu_asserts i_cpu_asserts (
    .clk(clk),
    .rst(rst),
    .re(re),
    .we(we),
    .addr(addr)
);

// ==== testbench/cpu_model.svh ====
// instruction-level reference; starts at address 0, stops at the store to 16'hfff0 or a step limit
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [15:0] model_mem [65536];
logic [15:0] exp_addr [$];
logic [15:0] exp_data [$];

// twelve operations, flags as n z c v
function automatic logic [15:0] model_alu(input logic [3:0] op, input logic [15:0] a,
                                          input logic [15:0] b, input logic [3:0] cc_old,
                                          output logic [3:0] cc_new);
    logic [16:0] s;
    logic [15:0] r;
    logic c;
    logic v;
    c = cc_old[1];
    v = cc_old[0];
    case (op)
        4'd0: s = {1'b0, a} + {1'b0, b};
        4'd1: s = {1'b0, a} + {1'b0, b} + cc_old[1];
        // subtract as add of complement, carry means no borrow
        4'd2: s = {1'b0, a} + {1'b0, ~b} + 17'd1;
        4'd3: s = {1'b0, a} + {1'b0, ~b} + cc_old[1];
        default: s = '0;
    endcase
    case (op)
        4'd4: r = a & b;
        4'd5: r = a | b;
        4'd6: r = a ^ b;
        4'd7: r = b;
        4'd8: r = a << b[3:0];
        4'd9: r = a >> b[3:0];
        4'd10: r = $signed(a) >>> b[3:0];
        4'd11: r = ~b;
        default: r = s[15:0];
    endcase
    if (op < 4'd4) begin
        c = s[16];
        // signed overflow, textbook add and subtract forms
        v = (op < 4'd2) ? (a[15] == b[15] && r[15] != a[15]) : (a[15] != b[15] && r[15] != a[15]);
    end
    cc_new = {r[15], r == 16'd0, c, v};
    return r;
endfunction

function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] cc);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = cc;
    case (cond)
        4'd0: return z;
        4'd1: return !z;
        4'd2: return c;
        4'd3: return !c;
        4'd4: return n;
        4'd5: return !n;
        4'd6: return v;
        4'd7: return !v;
        4'd8: return c && !z;
        4'd9: return !c || z;
        4'd10: return n == v;
        4'd11: return n != v;
        4'd12: return !z && n == v;
        4'd13: return z || n != v;
        4'd14: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

task automatic run_model(input int step_limit);
    logic [15:0] r [8];
    logic [15:0] pc;
    logic [15:0] lr;
    logic [15:0] imm;
    logic [15:0] opnd;
    logic [15:0] ea;
    logic [15:0] res;
    logic [15:0] target;
    logic [3:0] cc;
    logic [3:0] cc_new;
    logic nv_form;
    logic regbr;
    cpu_pkg::instr_u ir;
    for (int i = 0; i < 8; i++) begin
        r[i] = '0;
    end
    pc = 16'h0000;
    lr = '0;
    cc = '0;
    for (int step = 0; step < step_limit; step++) begin
        ir = model_mem[pc];
        imm = model_mem[pc + 16'd1];
        nv_form = ir.br.group == 2'b10 && ir.br.cond == 4'hf;
        regbr = nv_form && (ir.op.mode[0] || ir.op.b != 3'd0);
        // pc past the whole instruction, as branches and links see it
        if ((ir.op.opcode <= 5'd13 && ir.op.mode == 2'b11) || (nv_form && !regbr)) begin
            pc = pc + 16'd2;
        end else begin
            pc = pc + 16'd1;
        end
        case (ir.op.mode)
            2'b10: opnd = r[ir.op.b];
            2'b11: opnd = imm;
            default: opnd = {{13{ir.op.mode[0]}}, ir.op.b};
        endcase
        if (ir.op.opcode <= 5'd11) begin
            res = model_alu(ir.op.opcode[3:0], r[ir.op.a], opnd, cc, cc_new);
            cc = cc_new;
            if (ir.op.d != 3'd0) begin
                r[ir.op.d] = res;
            end
        end else if (ir.op.opcode == 5'd12) begin
            ea = r[ir.op.a] + opnd;
            if (ir.op.d != 3'd0) begin
                r[ir.op.d] = model_mem[ea];
            end
        end else if (ir.op.opcode == 5'd13) begin
            ea = r[ir.op.a] + opnd;
            exp_addr.push_back(ea);
            exp_data.push_back(r[ir.op.d]);
            // program region is read only
            if (ea >= 16'h1000) begin
                model_mem[ea] = r[ir.op.d];
            end
            if (ea == 16'hfff0) begin
                return;
            end
        end else if (ir.br.group == 2'b10) begin
            if (!nv_form) begin
                if (cond_holds(ir.br.cond, cc)) begin
                    pc = pc + {{6{ir.br.offset[9]}}, ir.br.offset};
                end
            end else begin
                // target uses the old lr
                target = regbr ? (ir.op.mode[0] ? lr : r[ir.op.b]) : pc + imm;
                if (ir.br.offset[9]) begin
                    lr = pc;
                end
                pc = target;
            end
        end
    end
endtask

`endif

// ==== testbench/tb_cpu.sv ====
// random program below 16'h1000, checked store by store; ends at the 16'hfff0 marker store
`timescale 1ns/10ps

module tb_cpu;

    localparam int w = cpu_pkg::word_width;
    localparam int n_blocks = 60;

    logic clk;
    logic rst;
    logic [w-1:0] addr;
    logic [w-1:0] rdata;
    logic [w-1:0] wdata;
    logic re;
    logic we;
    // bus sampled mid cycle
    logic [w-1:0] addr_q;
    logic [w-1:0] wdata_q;
    logic re_q;
    logic we_q;
    logic [w-1:0] mem [65536];
    int seed = 32'h95646d15;
    int gen_pc;
    int n_seen;
    logic gen_done;

    `include "cpu_model.svh"

    cpu_top #(
        .reset_vector(16'hffff)
    ) i_cpu_top (
        .clk(clk),
        .rst(rst),
        .addr(addr),
        .rdata(rdata),
        .wdata(wdata),
        .re(re),
        .we(we)
    );

    always #4 clk = ~clk;

    function automatic int rand_below(input int n);
        return int'({1'b0, $random(seed)} % n);
    endfunction

    function automatic logic [w-1:0] op_word(input logic [4:0] opc, input logic [2:0] d,
                                             input logic [2:0] a, input logic [1:0] mode,
                                             input logic [2:0] b);
        cpu_pkg::instr_u i;
        i.op.opcode = opc;
        i.op.d = d;
        i.op.a = a;
        i.op.mode = mode;
        i.op.b = b;
        return i;
    endfunction

    task automatic emit(input logic [w-1:0] word);
        mem[gen_pc] = word;
        gen_pc++;
    endtask

    // alu, load or store with any operand mode
    task automatic emit_operate(input logic [4:0] opc, input int n_modes);
        logic [1:0] mode;
        mode = 2'(rand_below(n_modes));
        emit(op_word(opc, 3'(rand_below(8)), 3'(rand_below(8)), mode, 3'(rand_below(8))));
        if (mode == 2'b11) begin
            emit(16'($random(seed)));
        end
    endtask

    // forward skip over a store and up to two one-word alu instructions
    task automatic emit_skip(input logic [3:0] cond);
        int n;
        n = 1 + rand_below(3);
        emit({2'b10, cond, 10'(n)});
        emit_operate(5'd13, 3);
        for (int k = 1; k < n; k++) begin
            emit_operate(5'(rand_below(12)), 3);
        end
    endtask

    // call through long or register bl, return via lr to the word after the call
    task automatic emit_call(input logic use_reg);
        logic [2:0] x;
        x = 3'(1 + rand_below(7));
        if (use_reg) begin
            emit(op_word(5'd7, x, 3'd0, 2'b11, 3'd0));
            emit(16'(gen_pc + 4));
            emit({2'b10, 4'hf, 1'b1, 5'd0, 1'b0, x});
        end else begin
            emit({2'b10, 4'hf, 1'b1, 9'd0});
            emit(16'd2);
        end
        emit_operate(5'd13, 3);
        emit({2'b10, 4'he, 10'd2});
        emit_operate(5'd13, 3);
        emit({2'b10, 4'hf, 1'b0, 5'd0, 1'b1, 3'd0});
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [w-1:0] got,
                              input logic [w-1:0] expected);
        if (got !== expected) begin
            $display("FAILED time=%0t %s got %h expected %h", $time, name, got, expected);
            report_failure("store does not match the model");
        end
    endtask

    always @(negedge clk) begin
        addr_q <= addr;
        wdata_q <= wdata;
        re_q <= re;
        we_q <= we;
        if (!rst && we) begin
            if (n_seen >= exp_addr.size()) begin
                report_failure("store seen after the last expected store");
            end else begin
                check_word("addr", addr, exp_addr[n_seen]);
                check_word("wdata", wdata, exp_data[n_seen]);
            end
            n_seen++;
        end
    end

    // one-cycle synchronous memory, program region ignores writes
    always @(posedge clk) begin
        if (re_q) begin
            rdata <= mem[addr_q];
        end
        if (we_q && addr_q >= 16'h1000) begin
            mem[addr_q] <= wdata_q;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdata = '0;
        re_q = 1'b0;
        we_q = 1'b0;
        n_seen = 0;
        gen_done = 1'b0;
        gen_pc = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'($random(seed));
        end
        for (int blk = 0; blk < n_blocks; blk++) begin
            case (rand_below(6))
                0, 1: emit_operate(5'(rand_below(12)), 4);
                2: emit_operate(5'd12, 4);
                3: emit_operate(5'd13, 4);
                4: emit_skip(4'(rand_below(15)));
                default: emit_call(rand_below(2) == 1);
            endcase
        end
        // every short-branch condition, each after an op that sets all flags
        for (int c = 0; c < 15; c++) begin
            emit_operate(5'(rand_below(4)), 4);
            emit_skip(4'(c));
        end
        // marker store then branch to self
        emit(op_word(5'd7, 3'd1, 3'd0, 2'b11, 3'd0));
        emit(16'hfff0);
        emit(op_word(5'd13, 3'(rand_below(8)), 3'd1, 2'b00, 3'd0));
        emit({2'b10, 4'he, 10'h3ff});
        for (int i = 0; i < 65536; i++) begin
            model_mem[i] = mem[i];
        end
        run_model(20 * gen_pc);
        if (exp_addr.size() == 0 || exp_addr[exp_addr.size() - 1] != 16'hfff0) begin
            report_failure("model never reached the marker store");
        end
        gen_done = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (n_seen == exp_addr.size());
        // the self loop must stay silent
        repeat (50) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

    // about 20 cycles per generated word
    initial begin
        wait (gen_done);
        repeat (20 * gen_pc + 100) @(posedge clk);
        report_failure("timeout before all expected stores appeared");
    end

endmodule

// ==== tb.f ====
+incdir+testbench
rtl/cpu_pkg.sv
rtl/core_ifs.sv
rtl/alu.sv
rtl/regfile.sv
rtl/fetch_unit.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
testbench/cpu_asserts.sv
testbench/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_cpu
FILELIST ?= tb.f
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation did not finish cleanly"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
